// ==== verilog/sha256_pad_defines.svh ====
// sizes and constants of the SHA-256 single-block padder
`ifndef SHA256_PAD_DEFINES_SVH
`define SHA256_PAD_DEFINES_SVH

// ------------------------------
// block geometry
// ------------------------------
`define SHA_BLOCK_BITS      512     // one SHA-256 message block
`define SHA_BYTE_BITS       8

// longest message that still leaves room for marker and length
`define SHA_MAX_MSG_BYTES   55

// ------------------------------
// padding fields
// ------------------------------
`define SHA_PAD_MARKER      8'h80   // single 1 bit followed by zeros
`define SHA_LEN_FIELD_BYTES 8       // 64-bit big-endian bit count

// message SRAM read latency in cycles
`define SHA_MEM_LATENCY     1

`endif

// ==== verilog/sha256_pad_pkg.sv ====
// shared types of the padder: width typedefs, control states, SRAM request and byte write
`include "sha256_pad_defines.svh"

package sha256_pad_pkg;

	// ------------------------------
	// widths
	// ------------------------------

	// message length in bytes, 0 .. SHA_MAX_MSG_BYTES
	typedef logic [$clog2(`SHA_MAX_MSG_BYTES + 1) - 1:0] msg_len_t;

	typedef logic [$clog2(`SHA_BLOCK_BITS / `SHA_BYTE_BITS) - 1:0] mem_addr_t;  // SRAM byte address
	typedef logic [`SHA_BYTE_BITS - 1:0] msg_byte_t;

	// byte slot in the block, 0 is the most significant byte
	typedef logic [$clog2(`SHA_BLOCK_BITS / `SHA_BYTE_BITS) - 1:0] byte_idx_t;

	typedef logic [`SHA_BLOCK_BITS - 1:0] pad_block_t;

	// ------------------------------
	// control FSM
	// ------------------------------
	typedef enum logic [2:0] {
		st_idle,    // waiting for the first go
		st_load,    // length captured, block cleared, fetch kicked off
		st_fetch,   // first cycle of the fetch
		st_drain,   // reads and writes in flight
		st_finish,  // marker and length go in
		st_ready    // block held for the consumer
	} pad_state_t;

	// ------------------------------
	// records
	// ------------------------------
	typedef struct packed {
		logic      en;
		mem_addr_t addr;
	} mem_req_t;  // SRAM read request

	typedef struct packed {
		logic      valid;
		byte_idx_t idx;
		msg_byte_t data;
	} byte_wr_t;  // one byte into the block register

endpackage

// ==== verilog/pad_ctrl.sv ====
// control FSM of the padder: go/ready handshake, run length capture and run sequencing
`timescale 1ns/1ps
`include "sha256_pad_defines.svh"

module pad_ctrl (
	input  logic                     clock,
	input  logic                     regin_reset,
	input  logic                     go,
	input  sha256_pad_pkg::msg_len_t msg_len,
	input  logic                     fetch_done,
	output logic                     start_fetch,
	output logic                     clear,
	output logic                     finalize,
	output sha256_pad_pkg::msg_len_t run_len,
	output logic                     pad_rdy
);
	import sha256_pad_pkg::*;

	pad_state_t state;
	pad_state_t state_nxt;
	logic       go_accept;  // go seen while not busy

	assign go_accept = go && ((state == st_idle) || (state == st_ready));

	// ------------------------------
	// state register
	// ------------------------------
	always_ff @(posedge clock) begin
		if (regin_reset) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle, st_ready: begin
				if (go_accept) begin
					state_nxt = st_load;
				end
			end
			st_load: begin
				state_nxt = st_fetch;
			end
			st_fetch: begin
				// zero length finishes right here
				state_nxt = fetch_done ? st_finish : st_drain;
			end
			st_drain: begin
				if (fetch_done) begin
					state_nxt = st_finish;
				end
			end
			st_finish: begin
				state_nxt = st_ready;
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	// length stays put for the whole run and while ready
	always_ff @(posedge clock) begin
		if (go_accept) begin
			run_len <= msg_len;
		end
	end

	// ------------------------------
	// decoded strobes
	// ------------------------------
	assign start_fetch = (state == st_load);
	assign clear       = (state == st_load);     // same cycle as the fetch kick
	assign finalize    = (state == st_finish);
	assign pad_rdy     = (state == st_ready);

	// a run never starts with a message too long for one block
	assert property (@(posedge clock) disable iff (regin_reset)
		go_accept |=> (run_len <= `SHA_MAX_MSG_BYTES))
		else $error("pad_ctrl: message length %0d does not fit one block", run_len);

	// finalize only after the fetch reported done, and ready follows it
	assert property (@(posedge clock) disable iff (regin_reset)
		finalize |-> $past(fetch_done) ##1 pad_rdy)
		else $error("pad_ctrl: finalize out of sequence");

endmodule

// ==== verilog/msg_fetch.sv ====
// message fetch: SRAM address counter and latency pipeline that turns read data into byte writes
`timescale 1ns/1ps
`include "sha256_pad_defines.svh"

module msg_fetch (
	input  logic                      clock,
	input  logic                      regin_reset,
	input  logic                      start_fetch,
	input  sha256_pad_pkg::msg_len_t  run_len,
	input  sha256_pad_pkg::msg_byte_t mem_data,
	output sha256_pad_pkg::mem_req_t  mem_req,
	output sha256_pad_pkg::byte_wr_t  byte_wr,
	output logic                      fetch_done
);
	import sha256_pad_pkg::*;

	localparam int LAT = `SHA_MEM_LATENCY;

	msg_len_t     last_addr;           // address of the final message byte
	logic         req_last;            // request of the final byte is on the bus
	msg_byte_t    data_q;              // registered SRAM data
	logic [LAT:0] vld_pipe;
	logic [LAT:0] last_pipe;
	byte_idx_t    idx_pipe [LAT + 1];

	assign last_addr = run_len - 1'b1;
	assign req_last  = mem_req.en && (mem_req.addr == last_addr);

	// ------------------------------
	// address counter
	// ------------------------------
	always_ff @(posedge clock) begin
		if (regin_reset) begin
			mem_req <= '0;
		end else if (start_fetch) begin
			mem_req.en   <= (run_len != '0);  // nothing to read for an empty message
			mem_req.addr <= '0;
		end else if (req_last) begin
			mem_req.en <= 1'b0;
		end else if (mem_req.en) begin
			mem_req.addr <= mem_req.addr + 1'b1;
		end
	end

	// ------------------------------
	// latency pipeline
	// ------------------------------
	// stage 0 lines up with mem_data, stage LAT with data_q
	always_ff @(posedge clock) begin
		if (regin_reset) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe[0] <= mem_req.en;
			for (int i = 1; i <= LAT; i++) begin
				vld_pipe[i] <= vld_pipe[i - 1];
			end
		end
	end

	always_ff @(posedge clock) begin
		data_q       <= mem_data;
		idx_pipe[0]  <= byte_idx_t'(mem_req.addr);
		last_pipe[0] <= req_last;
		for (int i = 1; i <= LAT; i++) begin
			idx_pipe[i]  <= idx_pipe[i - 1];
			last_pipe[i] <= last_pipe[i - 1];
		end
	end

	assign byte_wr = '{valid: vld_pipe[LAT], idx: idx_pipe[LAT], data: data_q};

	// done once the final byte has gone out, or straight away for length 0
	always_ff @(posedge clock) begin
		if (regin_reset) begin
			fetch_done <= 1'b0;
		end else begin
			fetch_done <= (start_fetch && (run_len == '0)) ||
				(vld_pipe[LAT] && last_pipe[LAT]);
		end
	end

	assert property (@(posedge clock) disable iff (regin_reset)
		mem_req.en |-> (mem_req.addr < run_len))
		else $error("msg_fetch: address %0d past length %0d", mem_req.addr, run_len);

endmodule

// ==== verilog/pad_block_reg.sv ====
// padded block register: byte writes, clear per run, marker and length insertion
`timescale 1ns/1ps
`include "sha256_pad_defines.svh"

module pad_block_reg (
	input  logic                       clock,
	input  logic                       regin_reset,
	input  logic                       clear,
	input  sha256_pad_pkg::byte_wr_t   byte_wr,
	input  logic                       finalize,
	input  sha256_pad_pkg::msg_len_t   run_len,
	output sha256_pad_pkg::pad_block_t block
);
	import sha256_pad_pkg::*;

	localparam int BYTE_BITS   = `SHA_BYTE_BITS;
	localparam int BLOCK_BYTES = `SHA_BLOCK_BITS / `SHA_BYTE_BITS;
	localparam int LEN_BITS    = `SHA_LEN_FIELD_BYTES * `SHA_BYTE_BITS;

	logic [LEN_BITS - 1:0] bit_len;  // message length in bits

	// lsb position of a byte slot, slot 0 sits at the top of the block
	function automatic int byte_lsb(input byte_idx_t idx);
		int slot;
		slot = BLOCK_BYTES - 1 - int'(idx);
		return slot * BYTE_BITS;
	endfunction

	assign bit_len = LEN_BITS'(run_len) * LEN_BITS'(BYTE_BITS);

	// ------------------------------
	// block register
	// ------------------------------
	always_ff @(posedge clock) begin
		if (regin_reset || clear) begin
			block <= '0;  // zero fill doubles as the padding bytes
		end else begin
			if (byte_wr.valid) begin
				block[byte_lsb(byte_wr.idx) +: BYTE_BITS] <= byte_wr.data;
			end
			if (finalize) begin
				// marker right after the last message byte
				block[byte_lsb(byte_idx_t'(run_len)) +: BYTE_BITS] <= `SHA_PAD_MARKER;
				block[LEN_BITS - 1:0] <= bit_len;  // big-endian in the low bytes
			end
		end
	end

	// ------------------------------
	// checks
	// ------------------------------
	// message bytes must stay clear of marker room and length field
	assert property (@(posedge clock) disable iff (regin_reset)
		byte_wr.valid |-> (byte_wr.idx < `SHA_MAX_MSG_BYTES))
		else $error("pad_block_reg: byte write at index %0d", byte_wr.idx);

	// the fetch has drained before marker and length go in
	assert property (@(posedge clock) disable iff (regin_reset)
		finalize |-> !byte_wr.valid && !$past(byte_wr.valid))
		else $error("pad_block_reg: byte write overlaps finalize");

endmodule

// ==== verilog/sha256_padder.sv ====
// SHA-256 single-block padder top: control FSM, message fetch and block register
`timescale 1ns/1ps

module sha256_padder (
	input  logic                       clock,
	input  logic                       regin_reset,
	input  logic                       go,
	input  sha256_pad_pkg::msg_len_t   msg_len,
	input  sha256_pad_pkg::msg_byte_t  mem_data,
	output sha256_pad_pkg::mem_req_t   mem_req,
	output sha256_pad_pkg::pad_block_t block,
	output logic                       pad_rdy
);
	import sha256_pad_pkg::*;

	// ------------------------------
	// internal wiring
	// ------------------------------
	logic     start_fetch;  // one cycle, in load
	logic     clear;        // one cycle, in load
	logic     finalize;     // one cycle, in finish
	logic     fetch_done;
	msg_len_t run_len;      // length held for the run
	byte_wr_t byte_wr;

	// go/ready handshake and run sequencing
	pad_ctrl u_pad_ctrl (
		.clock       (clock),
		.regin_reset (regin_reset),
		.go          (go),
		.msg_len     (msg_len),
		.fetch_done  (fetch_done),
		.start_fetch (start_fetch),
		.clear       (clear),
		.finalize    (finalize),
		.run_len     (run_len),
		.pad_rdy     (pad_rdy)
	);

	// SRAM reads and their byte writes
	msg_fetch u_msg_fetch (
		.clock       (clock),
		.regin_reset (regin_reset),
		.start_fetch (start_fetch),
		.run_len     (run_len),
		.mem_data    (mem_data),
		.mem_req     (mem_req),
		.byte_wr     (byte_wr),
		.fetch_done  (fetch_done)
	);

	// block storage, held while pad_rdy is high
	pad_block_reg u_pad_block_reg (
		.clock       (clock),
		.regin_reset (regin_reset),
		.clear       (clear),
		.byte_wr     (byte_wr),
		.finalize    (finalize),
		.run_len     (run_len),
		.block       (block)
	);

endmodule

// ==== tb/tb_padder_tests.svh ====
// directed padder tests, run helpers and the reference padding model
`ifndef TB_PADDER_TESTS_SVH
`define TB_PADDER_TESTS_SVH

// bytes, marker, zeros, then the bit count big-endian in bytes 56 .. 63
function automatic pad_block_t build_expected_block(input int len);
	pad_block_t  exp;
	logic [63:0] bits;
	logic [7:0]  b;
	exp  = '0;
	bits = 64'(len) * 64'd8;
	for (int i = 0; i < 64; i++) begin
		if (i < len)       b = sram[i];
		else if (i == len) b = `SHA_PAD_MARKER;
		else if (i >= 56)  b = bits[8 * (63 - i) +: 8];
		else               b = 8'h00;
		exp = {exp[503:0], b};  // byte 0 ends up at the top
	end
	return exp;
endfunction

task automatic fill_random_sram();
	for (int i = 0; i < 64; i++) begin
		sram[i] = msg_byte_t'($urandom);
	end
endtask

task automatic start_run(input string name, input int len);
	@(negedge clock);
	addr_log.delete();
	msg_len = msg_len_t'(len);
	go      = 1'b1;
	@(negedge clock);
	go = 1'b0;
	check_flag({name, " ready drop"}, 1'b0, pad_rdy);
endtask

task automatic wait_for_ready(input string name);
	int cycles;
	cycles = 0;
	while (!pad_rdy && (cycles < RUN_BOUND)) begin
		@(negedge clock);
		cycles++;
	end
	if (!pad_rdy) begin
		fail_count++;
		$display("%s: ready never came within %0d cycles", name, RUN_BOUND);
	end
endtask

// one request per byte, addresses 0 upward
task automatic check_addrs(input string name, input int len);
	check_flag({name, " request count"}, 1'b1, addr_log.size() == len);
	for (int i = 0; i < addr_log.size(); i++) begin
		check_addr({name, " request address"}, mem_addr_t'(i), addr_log[i]);
	end
endtask

task automatic run_and_check(input string name, input int len);
	start_run(name, len);
	wait_for_ready(name);
	check_block(name, build_expected_block(len), block);
	check_addrs(name, len);
endtask

// ------------------------------
// directed tests
// ------------------------------
task automatic test_reset_state();
	@(negedge clock);
	check_flag("reset pad_rdy", 1'b0, pad_rdy);
	check_flag("reset mem_req.en", 1'b0, mem_req.en);
	check_block("reset block", '0, block);
endtask

task automatic test_abc();
	pad_block_t exp;
	sram[0] = 8'h61;
	sram[1] = 8'h62;
	sram[2] = 8'h63;
	exp = '0;
	exp[511:480] = 32'h61626380;
	exp[63:0]    = 64'h18;
	start_run("abc", 3);
	wait_for_ready("abc");
	check_block("abc", exp, block);
	check_addrs("abc", 3);
endtask

task automatic test_edge_lengths();
	pad_block_t exp;
	exp = '0;
	exp[511:504] = 8'h80;  // empty message, length field stays zero
	start_run("length 0", 0);
	wait_for_ready("length 0");
	check_block("length 0", exp, block);
	check_addrs("length 0", 0);
	fill_random_sram();
	run_and_check("length 55", 55);
	check_flag("length 55 bit count", 1'b1, block[63:0] == 64'd440);
endtask

// long and short runs alternate, each started straight from ready
task automatic test_random_runs();
	int len;
	for (int n = 0; n < 8; n++) begin
		fill_random_sram();
		if (n % 2 == 0) len = $urandom_range(40, `SHA_MAX_MSG_BYTES);
		else            len = $urandom_range(0, 20);
		run_and_check($sformatf("random run %0d len %0d", n, len), len);
	end
endtask

task automatic test_busy_go();
	fill_random_sram();
	start_run("busy go", 30);
	repeat (3) @(negedge clock);
	msg_len = msg_len_t'(10);  // a different length that must not be taken
	go      = 1'b1;
	@(negedge clock);
	go = 1'b0;
	wait_for_ready("busy go");
	check_block("busy go", build_expected_block(30), block);
	check_addrs("busy go", 30);
endtask

`endif

// ==== tb/tb_sha256_padder.sv ====
// testbench top of the padder: clock, reset, message SRAM model, watchdog, compare tasks
`timescale 1ns/1ps
`include "sha256_pad_defines.svh"

module tb_sha256_padder;
	import sha256_pad_pkg::*;

	localparam int LAT        = `SHA_MEM_LATENCY;
	localparam int CLK_PERIOD = 20;
	localparam int RUN_BOUND  = `SHA_MAX_MSG_BYTES + 20;  // cycles allowed per run
	localparam int NUM_TESTS  = 13;                       // padding runs plus reset
	localparam int WATCHDOG_NS = NUM_TESTS * RUN_BOUND * CLK_PERIOD;

	logic       clock;
	logic       regin_reset;
	logic       go;
	msg_len_t   msg_len;
	msg_byte_t  mem_data;
	mem_req_t   mem_req;
	pad_block_t block;
	logic       pad_rdy;

	msg_byte_t  sram [64];      // message SRAM contents
	msg_byte_t  rd_pipe [LAT];  // read data in flight
	mem_addr_t  addr_log [$];   // addresses requested during the current run
	int         mismatch_count;
	int         fail_count;

	sha256_padder DUT (
		.clock       (clock),
		.regin_reset (regin_reset),
		.go          (go),
		.msg_len     (msg_len),
		.mem_data    (mem_data),
		.mem_req     (mem_req),
		.block       (block),
		.pad_rdy     (pad_rdy)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	// ------------------------------
	// SRAM model
	// ------------------------------
	always @(posedge clock) begin
		if (mem_req.en) begin
			rd_pipe[0] <= sram[mem_req.addr];
		end
		for (int i = 1; i < LAT; i++) begin
			rd_pipe[i] <= rd_pipe[i - 1];
		end
	end

	assign mem_data = rd_pipe[LAT - 1];

	// request bus is registered, so it is stable at the falling edge
	always @(negedge clock) begin
		if (mem_req.en) begin
			addr_log.push_back(mem_req.addr);
		end
	end

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic check_block(input string name, input pad_block_t exp, input pad_block_t act);
		if (exp !== act) begin
			mismatch_count++;
			$display("Mismatch %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
		if (exp !== act) begin
			mismatch_count++;
			$display("Mismatch %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			mismatch_count++;
			$display("Mismatch %s expected %b actual %b", name, exp, act);
		end
	endtask

	`include "tb_padder_tests.svh"

	// ------------------------------
	// watchdog
	// ------------------------------
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog: the test sequence did not finish in %0d ns", WATCHDOG_NS);
		$display("Errors found");
		$finish;
	end

	initial begin
		clock          = 1'b0;
		regin_reset    = 1'b1;
		go             = 1'b0;
		msg_len        = '0;
		rd_pipe        = '{default: '0};
		mismatch_count = 0;
		fail_count     = 0;
		void'($urandom(49));
		fill_random_sram();
		repeat (8) @(negedge clock);
		regin_reset = 1'b0;

		test_reset_state();
		test_abc();
		test_edge_lengths();
		test_random_runs();
		test_busy_go();

		$display("mismatches: %0d, other failures: %0d", mismatch_count, fail_count);
		if ((mismatch_count == 0) && (fail_count == 0)) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+verilog
+incdir+tb
verilog/sha256_pad_pkg.sv
verilog/pad_ctrl.sv
verilog/msg_fetch.sv
verilog/pad_block_reg.sv
verilog/sha256_padder.sv
tb/tb_sha256_padder.sv

// ==== Bender.yml ====
package:
  name: sha256_padder

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sha256_pad_pkg.sv
      - verilog/pad_ctrl.sv
      - verilog/msg_fetch.sv
      - verilog/pad_block_reg.sv
      - verilog/sha256_padder.sv
  - target: test
    include_dirs:
      - verilog
      - tb
    files:
      - tb/tb_sha256_padder.sv
